/* design/uart_ctl.sv */
/* UART controller top level
   Register block, TX path (FIFO, serializer) and RX path (deserializer, FIFO) */

`timescale 1ns/1ps

module uart_ctl import uart_pkg::*; (
  input  logic    tcb_wrc,
  input  logic    arst_n,
  // Bus channels
  input  wr_req_t wr_req,
  input  rd_req_t rd_req,
  output rd_rsp_t rd_rsp,
  // Serial lines
  input  logic    uart_rxd,
  output logic    uart_txd,
  // Interrupts
  output logic    irq_tx,
  output logic    irq_rx
);

  byte_str_t        tx_bus;      // Registers to TX FIFO
  byte_str_t        tx_str;      // TX FIFO to serializer
  logic             tx_str_rdy;
  byte_str_t        rx_str;      // Deserializer to RX FIFO
  byte_str_t        rx_bus;      // RX FIFO to registers
  logic             rx_pop;
  logic [CNT_W-1:0] tx_cnt;
  logic [CNT_W-1:0] rx_cnt;
  logic [BDR_W-1:0] tx_bdr;
  logic [BDR_W-1:0] rx_bdr;
  logic [BDR_W-1:0] rx_smp;

  uart_regs u_regs (
    .tcb_wrc (tcb_wrc),
    .arst_n  (arst_n),
    .wr_req  (wr_req),
    .rd_req  (rd_req),
    .rd_rsp  (rd_rsp),
    .tx_str  (tx_bus),
    .rx_pop  (rx_pop),
    .tx_cnt  (tx_cnt),
    .rx_cnt  (rx_cnt),
    .rx_dat  (rx_bus.dat),
    .tx_bdr  (tx_bdr),
    .rx_bdr  (rx_bdr),
    .rx_smp  (rx_smp),
    .irq_tx  (irq_tx),
    .irq_rx  (irq_rx)
  );

  //////////////////////////////
  // TX path
  //////////////////////////////

  uart_fifo u_tx_fifo (
    .tcb_wrc (tcb_wrc),
    .arst_n  (arst_n),
    .sti     (tx_bus),
    .sti_rdy (),               // Full FIFO drops the byte
    .sto     (tx_str),
    .sto_rdy (tx_str_rdy),
    .cnt     (tx_cnt)
  );

  uart_ser u_ser (
    .tcb_wrc (tcb_wrc),
    .arst_n  (arst_n),
    .cfg_bdr (tx_bdr),
    .str     (tx_str),
    .str_rdy (tx_str_rdy),
    .txd     (uart_txd)
  );

  //////////////////////////////
  // RX path
  //////////////////////////////

  uart_des u_des (
    .tcb_wrc (tcb_wrc),
    .arst_n  (arst_n),
    .cfg_bdr (rx_bdr),
    .cfg_smp (rx_smp),
    .rxd     (uart_rxd),
    .str     (rx_str)
  );

  uart_fifo u_rx_fifo (
    .tcb_wrc (tcb_wrc),
    .arst_n  (arst_n),
    .sti     (rx_str),
    .sti_rdy (),               // Deserializer cannot wait
    .sto     (rx_bus),
    .sto_rdy (rx_pop),
    .cnt     (rx_cnt)
  );

endmodule : uart_ctl

/* design/uart_des.sv */
/* UART deserializer
   Samples the receive line at a programmable phase and emits complete bytes */

`timescale 1ns/1ps

module uart_des import uart_pkg::*; (
  input  logic             tcb_wrc,
  input  logic             arst_n,
  // Configuration
  input  logic [BDR_W-1:0] cfg_bdr,  // Bit period minus one
  input  logic [BDR_W-1:0] cfg_smp,  // Sample phase within a bit
  // Serial in
  input  logic             rxd,
  // Byte stream out, no back-pressure
  output byte_str_t        str
);

  logic [1:0]        rxd_sync;  // Two-flop synchronizer
  logic              rxd_s;     // Synchronized line
  logic              rxd_l;     // Previous synchronized level
  logic              busy;
  logic [BDR_W-1:0]  bdr_cnt;   // Cycles into current bit
  logic [IDX_W-1:0]  bit_idx;
  logic [DATA_W-1:0] shr;
  logic              str_vld;
  logic              start;
  logic              smp_hit;
  logic              last_bit;

  assign rxd_s    = rxd_sync[1];
  assign start    = ~busy & rxd_l & ~rxd_s;       // Falling edge while idle
  assign smp_hit  = busy & (bdr_cnt == cfg_smp);
  assign last_bit = (bit_idx == IDX_W'(FRM_LEN-1));

  assign str = '{vld: str_vld, dat: shr};

  //////////////////////////////
  // Synchronizer
  //////////////////////////////

  always_ff @(posedge tcb_wrc or negedge arst_n) begin
    if (!arst_n) begin
      rxd_sync <= 2'b11;
      rxd_l    <= 1'b1;
    end else begin
      rxd_sync <= {rxd_sync[0], rxd};
      rxd_l    <= rxd_s;
    end
  end

  //////////////////////////////
  // Frame control
  //////////////////////////////

  always_ff @(posedge tcb_wrc or negedge arst_n) begin
    if (!arst_n) begin
      busy    <= 1'b0;
      bdr_cnt <= '0;
      bit_idx <= '0;
      str_vld <= 1'b0;
    end else begin
      str_vld <= smp_hit & last_bit & rxd_s;  // Keep only a clean stop bit
      if (start) begin
        busy    <= 1'b1;
        bdr_cnt <= '0;
        bit_idx <= '0;
      end else if (busy) begin
        if (bdr_cnt == cfg_bdr) begin
          bdr_cnt <= '0;
          bit_idx <= bit_idx + 1'b1;
        end else begin
          bdr_cnt <= bdr_cnt + 1'b1;
        end
        // Back to idle right at the stop sample
        if (smp_hit && last_bit) busy <= 1'b0;
      end
    end
  end

  // Data bits shift in LSB first
  always_ff @(posedge tcb_wrc) begin
    if (smp_hit && (bit_idx != '0) && !last_bit) shr <= {rxd_s, shr[DATA_W-1:1]};
  end

  // One pulse per frame
  a_vld_pulse: assert property (
    @(posedge tcb_wrc) disable iff (!arst_n)
    str.vld |=> !str.vld
  );

endmodule : uart_des

/* design/uart_fifo.sv */
/* Byte FIFO
   Circular buffer with a valid/ready stream on each side and a load count */

`timescale 1ns/1ps

module uart_fifo import uart_pkg::*; (
  input  logic             tcb_wrc,
  input  logic             arst_n,
  // Write side
  input  byte_str_t        sti,
  output logic             sti_rdy,
  // Read side
  output byte_str_t        sto,
  input  logic             sto_rdy,
  // Status
  output logic [CNT_W-1:0] cnt
);

  logic [DATA_W-1:0] mem [FIFO_DEPTH];  // Byte storage
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic              push;
  logic              pop;

  //////////////////////////////
  // Handshakes
  //////////////////////////////

  assign sti_rdy = (cnt != CNT_W'(FIFO_DEPTH));  // Low when full
  assign sto     = '{vld: (cnt != '0), dat: mem[rd_ptr]};

  assign push = sti.vld & sti_rdy;   // Extra bytes fall on the floor
  assign pop  = sto.vld & sto_rdy;

  //////////////////////////////
  // Pointers and load
  //////////////////////////////

  always_ff @(posedge tcb_wrc or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      // Push with pop leaves the load alone
      case ({push, pop})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: ;
      endcase
    end
  end

  // Storage write
  always_ff @(posedge tcb_wrc) begin
    if (push) mem[wr_ptr] <= sti.dat;
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Load stays within the buffer
  a_cnt_max: assert property (
    @(posedge tcb_wrc) disable iff (!arst_n)
    cnt <= CNT_W'(FIFO_DEPTH)
  );

  // Pops only where the pointers show stored data
  a_no_pop_empty: assert property (
    @(posedge tcb_wrc) disable iff (!arst_n)
    pop |-> (wr_ptr != rd_ptr) || (cnt == CNT_W'(FIFO_DEPTH))
  );

endmodule : uart_fifo

/* design/uart_pkg.sv */
/* UART controller package
   Widths, register map, reset values and the bus and stream structs */

package uart_pkg;

  //////////////////////////////
  // Widths and sizes
  //////////////////////////////

  localparam int unsigned DATA_W     = 8;                    // Bits per character
  localparam int unsigned BDR_W      = 8;                    // Bit period and sample phase
  localparam int unsigned FIFO_DEPTH = 16;                   // Entries per FIFO
  localparam int unsigned CNT_W      = 5;                    // FIFO load, 0..FIFO_DEPTH
  localparam int unsigned PTR_W      = $clog2(FIFO_DEPTH);   // FIFO pointer
  localparam int unsigned ADR_W      = 6;                    // Decoded bus address
  localparam int unsigned BUS_W      = 32;                   // Bus data
  localparam int unsigned FRM_LEN    = DATA_W + 2;           // Start, data, stop
  localparam int unsigned IDX_W      = 4;                    // Bit index within a frame

  //////////////////////////////
  // Register map
  //////////////////////////////

  // TX side
  localparam logic [ADR_W-1:0] ADR_TX_DAT = 6'h00;  // Push into TX FIFO
  localparam logic [ADR_W-1:0] ADR_TX_CNT = 6'h04;  // TX FIFO load
  localparam logic [ADR_W-1:0] ADR_TX_BDR = 6'h08;  // TX bit period minus one
  localparam logic [ADR_W-1:0] ADR_TX_IRQ = 6'h10;  // TX interrupt level
  // RX side
  localparam logic [ADR_W-1:0] ADR_RX_DAT = 6'h20;  // Pop from RX FIFO
  localparam logic [ADR_W-1:0] ADR_RX_CNT = 6'h24;  // RX FIFO load
  localparam logic [ADR_W-1:0] ADR_RX_BDR = 6'h28;  // RX bit period minus one
  localparam logic [ADR_W-1:0] ADR_RX_SMP = 6'h2C;  // RX sample phase
  localparam logic [ADR_W-1:0] ADR_RX_IRQ = 6'h30;  // RX interrupt level

  // Reset values
  localparam logic [BDR_W-1:0] TX_BDR_RST = 8'd3;
  localparam logic [BDR_W-1:0] RX_BDR_RST = 8'd3;
  localparam logic [BDR_W-1:0] RX_SMP_RST = 8'd1;
  localparam logic [CNT_W-1:0] TX_IRQ_RST = '0;
  localparam logic [CNT_W-1:0] RX_IRQ_RST = '0;

  //////////////////////////////
  // Bus and stream structs
  //////////////////////////////

  typedef struct packed {
    logic             vld;
    logic [ADR_W-1:0] adr;
    logic [BUS_W-1:0] wdt;
  } wr_req_t;

  typedef struct packed {
    logic             vld;
    logic [ADR_W-1:0] adr;
  } rd_req_t;

  typedef struct packed {
    logic [BUS_W-1:0] rdt;
  } rd_rsp_t;

  // Forward half only, ready runs the other way
  typedef struct packed {
    logic              vld;
    logic [DATA_W-1:0] dat;
  } byte_str_t;

endpackage : uart_pkg

/* design/uart_regs.sv */
/* UART register block
   Bus decode, configuration registers, read mux and level interrupts */

`timescale 1ns/1ps

module uart_regs import uart_pkg::*; (
  input  logic              tcb_wrc,
  input  logic              arst_n,
  // Bus channels
  input  wr_req_t           wr_req,
  input  rd_req_t           rd_req,
  output rd_rsp_t           rd_rsp,
  // FIFO side
  output byte_str_t         tx_str,
  output logic              rx_pop,
  input  logic [CNT_W-1:0]  tx_cnt,
  input  logic [CNT_W-1:0]  rx_cnt,
  input  logic [DATA_W-1:0] rx_dat,
  // Configuration out
  output logic [BDR_W-1:0]  tx_bdr,
  output logic [BDR_W-1:0]  rx_bdr,
  output logic [BDR_W-1:0]  rx_smp,
  // Interrupts
  output logic              irq_tx,
  output logic              irq_rx
);

  logic [CNT_W-1:0] tx_irq;  // TX level, load below it raises irq_tx
  logic [CNT_W-1:0] rx_irq;  // RX level, load above it raises irq_rx

  //////////////////////////////
  // Write channel
  //////////////////////////////

  always_ff @(posedge tcb_wrc or negedge arst_n) begin
    if (!arst_n) begin
      tx_bdr <= TX_BDR_RST;
      tx_irq <= TX_IRQ_RST;
      rx_bdr <= RX_BDR_RST;
      rx_smp <= RX_SMP_RST;
      rx_irq <= RX_IRQ_RST;
    end else if (wr_req.vld) begin
      case (wr_req.adr)
        ADR_TX_BDR: tx_bdr <= wr_req.wdt[BDR_W-1:0];
        ADR_TX_IRQ: tx_irq <= wr_req.wdt[CNT_W-1:0];
        ADR_RX_BDR: rx_bdr <= wr_req.wdt[BDR_W-1:0];
        ADR_RX_SMP: rx_smp <= wr_req.wdt[BDR_W-1:0];
        ADR_RX_IRQ: rx_irq <= wr_req.wdt[CNT_W-1:0];
        default:    ;  // Data and status are not registers here
      endcase
    end
  end

  // TX data goes straight to the FIFO
  assign tx_str = '{vld: wr_req.vld & (wr_req.adr == ADR_TX_DAT),
                    dat: wr_req.wdt[DATA_W-1:0]};

  //////////////////////////////
  // Read channel
  //////////////////////////////

  always_comb begin
    case (rd_req.adr)
      ADR_TX_CNT: rd_rsp.rdt = BUS_W'(tx_cnt);
      ADR_TX_BDR: rd_rsp.rdt = BUS_W'(tx_bdr);
      ADR_TX_IRQ: rd_rsp.rdt = BUS_W'(tx_irq);
      ADR_RX_DAT: rd_rsp.rdt = BUS_W'(rx_dat);  // Valid only with RX load nonzero
      ADR_RX_CNT: rd_rsp.rdt = BUS_W'(rx_cnt);
      ADR_RX_BDR: rd_rsp.rdt = BUS_W'(rx_bdr);
      ADR_RX_SMP: rd_rsp.rdt = BUS_W'(rx_smp);
      ADR_RX_IRQ: rd_rsp.rdt = BUS_W'(rx_irq);
      default:    rd_rsp.rdt = '0;              // Unmapped
    endcase
  end

  assign rx_pop = rd_req.vld & (rd_req.adr == ADR_RX_DAT);  // Pop on data read

  //////////////////////////////
  // Interrupts
  //////////////////////////////

  always_ff @(posedge tcb_wrc or negedge arst_n) begin
    if (!arst_n) begin
      irq_tx <= 1'b0;
      irq_rx <= 1'b0;
    end else begin
      irq_tx <= (tx_cnt < tx_irq);
      irq_rx <= (rx_cnt > rx_irq);
    end
  end

  // Address must be known on any access
  a_wr_adr_known: assert property (
    @(posedge tcb_wrc) disable iff (!arst_n)
    wr_req.vld |-> !$isunknown(wr_req.adr)
  );
  a_rd_adr_known: assert property (
    @(posedge tcb_wrc) disable iff (!arst_n)
    rd_req.vld |-> !$isunknown(rd_req.adr)
  );

endmodule : uart_regs

/* design/uart_ser.sv */
/* UART serializer
   Turns stream bytes into 8N1 frames at a programmable bit period */

`timescale 1ns/1ps

module uart_ser import uart_pkg::*; (
  input  logic             tcb_wrc,
  input  logic             arst_n,
  // Configuration
  input  logic [BDR_W-1:0] cfg_bdr,  // Bit period minus one
  // Byte stream in
  input  byte_str_t        str,
  output logic             str_rdy,
  // Serial out
  output logic             txd
);

  logic              busy;     // Frame in flight
  logic [BDR_W-1:0]  bdr_cnt;  // Cycles left in the current bit
  logic [IDX_W-1:0]  bit_idx;  // 0 start, 1..8 data, 9 stop
  logic [DATA_W:0]   shr;      // Remaining data bits, then stop
  logic              pop;
  logic              bit_end;

  assign str_rdy = ~busy;              // Take a byte only when idle
  assign pop     = str.vld & str_rdy;
  assign bit_end = busy & (bdr_cnt == '0);

  //////////////////////////////
  // Frame control
  //////////////////////////////

  always_ff @(posedge tcb_wrc or negedge arst_n) begin
    if (!arst_n) begin
      busy    <= 1'b0;
      bdr_cnt <= '0;
      bit_idx <= '0;
      txd     <= 1'b1;                 // Line idles high
    end else if (pop) begin
      busy    <= 1'b1;
      bdr_cnt <= cfg_bdr;
      bit_idx <= '0;
      txd     <= 1'b0;                 // Start bit next cycle
    end else if (busy) begin
      if (!bit_end) begin
        bdr_cnt <= bdr_cnt - 1'b1;
      end else begin
        bdr_cnt <= cfg_bdr;
        if (bit_idx == IDX_W'(FRM_LEN-1)) begin
          busy <= 1'b0;                // Stop bit done
        end else begin
          bit_idx <= bit_idx + 1'b1;
          txd     <= shr[0];           // LSB first
        end
      end
    end
  end

  // Shift register, loaded with the stop bit on top
  always_ff @(posedge tcb_wrc) begin
    if (pop)          shr <= {1'b1, str.dat};
    else if (bit_end) shr <= {1'b1, shr[DATA_W:1]};
  end

  // Idle line is always high
  a_idle_high: assert property (
    @(posedge tcb_wrc) disable iff (!arst_n)
    !busy |-> txd
  );

endmodule : uart_ser

/* files.f */
design/uart_pkg.sv
design/uart_fifo.sv
design/uart_ser.sv
design/uart_des.sv
design/uart_regs.sv
design/uart_ctl.sv
verification/uart_ctl_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the UART controller simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module uart_ctl_tb -o uart_ctl_sim

./obj_dir/uart_ctl_sim > sim.log 2>&1
cat sim.log

if grep -q '>>> FAIL' sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

/* verification/uart_ctl_tb.sv */
/* UART controller testbench
   Bus tasks, serial loopback and concurrent checks on interrupts and loads */

`timescale 1ns/1ps

module uart_ctl_tb import uart_pkg::*; ();

  logic              tcb_wrc;
  logic              arst_n;
  wr_req_t           wr_req;
  rd_req_t           rd_req;
  rd_rsp_t           rd_rsp;
  logic              uart_rxd;
  logic              uart_txd;
  logic              irq_tx;
  logic              irq_rx;
  logic [CNT_W-1:0]  tx_lvl;          // Programmed TX level tracked on writes
  logic [CNT_W-1:0]  rx_lvl;
  logic [DATA_W-1:0] exp_q [$];       // Bytes expected on the RX side
  int unsigned       mismatches = 0;
  int unsigned       timeouts   = 0;

  assign uart_rxd = uart_txd;         // Serial loopback

  uart_ctl u_uart_ctl (.*);

  initial begin
    tcb_wrc = 1'b0;
    forever #2 tcb_wrc = ~tcb_wrc;    // 4 ns period
  end

  //////////////////////////////
  // Concurrent checks
  //////////////////////////////

  // irq_tx follows the TX load one cycle later
  a_irq_tx: assert property (@(posedge tcb_wrc) disable iff (!arst_n)
    (rd_req.vld && rd_req.adr == ADR_TX_CNT) |=>
      (irq_tx == ($past(rd_rsp.rdt) < BUS_W'(tx_lvl))))
  else begin
    mismatches += 1;
    $display("MISMATCH @%0t irq_tx: got %0b, expected %0b",
             $time, $sampled(irq_tx), !$sampled(irq_tx));
  end

  // irq_rx likewise with load above level
  a_irq_rx: assert property (@(posedge tcb_wrc) disable iff (!arst_n)
    (rd_req.vld && rd_req.adr == ADR_RX_CNT) |=>
      (irq_rx == ($past(rd_rsp.rdt) > BUS_W'(rx_lvl))))
  else begin
    mismatches += 1;
    $display("MISMATCH @%0t irq_rx: got %0b, expected %0b",
             $time, $sampled(irq_rx), !$sampled(irq_rx));
  end

  a_tx_cnt_max: assert property (@(posedge tcb_wrc) disable iff (!arst_n)
    (rd_req.vld && rd_req.adr == ADR_TX_CNT) |-> (rd_rsp.rdt <= BUS_W'(FIFO_DEPTH)))
  else begin
    mismatches += 1;
    $display("MISMATCH @%0t tx_cnt: got %0d, expected at most %0d",
             $time, $sampled(rd_rsp.rdt), FIFO_DEPTH);
  end

  //////////////////////////////
  // Bus tasks
  //////////////////////////////

  task automatic check_val(input string name, input logic [BUS_W-1:0] got,
                           input logic [BUS_W-1:0] exp);
    assert (got === exp) else begin
      mismatches += 1;
      $display("MISMATCH @%0t %s: got %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic bus_write(input logic [ADR_W-1:0] adr, input logic [BUS_W-1:0] wdt);
    @(negedge tcb_wrc);
    wr_req = '{vld: 1'b1, adr: adr, wdt: wdt};
    if (adr == ADR_TX_IRQ) tx_lvl = wdt[CNT_W-1:0];
    if (adr == ADR_RX_IRQ) rx_lvl = wdt[CNT_W-1:0];
    @(negedge tcb_wrc);
    wr_req.vld = 1'b0;
  endtask

  task automatic bus_read(input logic [ADR_W-1:0] adr, output logic [BUS_W-1:0] rdt);
    @(negedge tcb_wrc);
    rd_req = '{vld: 1'b1, adr: adr};
    #1;
    rdt = rd_rsp.rdt;                 // Mid low phase where data has settled
    @(negedge tcb_wrc);
    rd_req.vld = 1'b0;
  endtask

  task automatic read_expect(input logic [ADR_W-1:0] adr, input logic [BUS_W-1:0] exp,
                             input string name);
    logic [BUS_W-1:0] rdt;
    bus_read(adr, rdt);
    check_val(name, rdt, exp);
  endtask

  // Random write then readback masked to w bits
  task automatic cfg_check(input logic [ADR_W-1:0] adr, input int unsigned w,
                           input string name);
    logic [BUS_W-1:0] v;
    v = $urandom;
    bus_write(adr, v);
    read_expect(adr, v & ((32'h1 << w) - 1), name);
  endtask

  // Back-to-back TX data writes one per cycle
  task automatic push_bytes(input int unsigned n);
    logic [DATA_W-1:0] b;
    for (int unsigned i = 0; i < n; i++) begin
      @(negedge tcb_wrc);
      b = DATA_W'($urandom);
      exp_q.push_back(b);
      wr_req = '{vld: 1'b1, adr: ADR_TX_DAT, wdt: BUS_W'(b)};
    end
    @(negedge tcb_wrc);
    wr_req.vld = 1'b0;
  endtask

  task automatic poll_tx_cnt(input int unsigned n);
    logic [BUS_W-1:0] c;
    repeat (n) bus_read(ADR_TX_CNT, c);
  endtask

  task automatic wait_rx_cnt(input int unsigned target, input int unsigned limit);
    logic [BUS_W-1:0] c;
    int unsigned      n;
    c = '0;
    n = 0;
    while (c < target && n < limit) begin
      bus_read(ADR_RX_CNT, c);
      n++;
    end
    if (c < target) begin
      timeouts += 1;
      $display("Timeout: RX load stuck at %0d while waiting for %0d", c, target);
    end
  endtask

  task automatic wait_irq_rx(input logic level, input int unsigned limit);
    int unsigned n;
    n = 0;
    while (irq_rx !== level && n < limit) begin
      @(negedge tcb_wrc);
      n++;
    end
    if (irq_rx !== level) begin
      timeouts += 1;
      $display("Timeout: irq_rx never went to %0b", level);
    end
  endtask

  // Count must drop by one per pop
  task automatic pop_check(input int unsigned n);
    for (int unsigned i = 0; i < n; i++) begin
      read_expect(ADR_RX_CNT, BUS_W'(n - i), "rx_cnt");
      read_expect(ADR_RX_DAT, BUS_W'(exp_q.pop_front()), "rx_dat");
    end
  endtask

  // Pops bytes as they arrive
  task automatic drain_rx(input int unsigned n, input int unsigned limit);
    logic [BUS_W-1:0] c;
    int unsigned      got;
    int unsigned      polls;
    got   = 0;
    polls = 0;
    while (got < n && polls < limit) begin
      bus_read(ADR_RX_CNT, c);
      if (c != '0) begin
        read_expect(ADR_RX_DAT, BUS_W'(exp_q.pop_front()), "rx_dat");
        got++;
      end
      polls++;
    end
    if (got < n) begin
      timeouts += 1;
      $display("Timeout: only %0d of %0d bytes arrived on the RX side", got, n);
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int unsigned      per;
    logic [ADR_W-1:0] holes [4];
    void'($urandom(32'hd464));
    holes  = '{6'h00, 6'h0C, 6'h1C, 6'h3C};   // Unmapped for reads
    arst_n = 1'b0;
    wr_req = '0;
    rd_req = '0;
    tx_lvl = TX_IRQ_RST;
    rx_lvl = RX_IRQ_RST;
    repeat (16) @(posedge tcb_wrc);
    @(negedge tcb_wrc);
    arst_n = 1'b1;

    // Reset state
    check_val("uart_txd", BUS_W'(uart_txd), 1);
    check_val("irq_tx", BUS_W'(irq_tx), 0);
    check_val("irq_rx", BUS_W'(irq_rx), 0);
    read_expect(ADR_TX_BDR, BUS_W'(TX_BDR_RST), "tx_bdr");
    read_expect(ADR_RX_BDR, BUS_W'(RX_BDR_RST), "rx_bdr");
    read_expect(ADR_RX_SMP, BUS_W'(RX_SMP_RST), "rx_smp");
    read_expect(ADR_TX_IRQ, BUS_W'(TX_IRQ_RST), "tx_irq");
    read_expect(ADR_RX_IRQ, BUS_W'(RX_IRQ_RST), "rx_irq");

    // Configuration readback
    cfg_check(ADR_TX_BDR, BDR_W, "tx_bdr");
    cfg_check(ADR_RX_BDR, BDR_W, "rx_bdr");
    cfg_check(ADR_RX_SMP, BDR_W, "rx_smp");
    cfg_check(ADR_TX_IRQ, CNT_W, "tx_irq");
    cfg_check(ADR_RX_IRQ, CNT_W, "rx_irq");
    foreach (holes[i]) read_expect(holes[i], '0, "unmapped");

    // Loopback with the same period both ways and a mid-bit sample
    per = 6 + $urandom % 8;
    bus_write(ADR_TX_BDR, per - 1);
    bus_write(ADR_RX_BDR, per - 1);
    bus_write(ADR_RX_SMP, per / 2);
    push_bytes(8);
    wait_rx_cnt(8, 2000);
    pop_check(8);

    // Interrupts during a burst
    bus_write(ADR_TX_IRQ, 4);
    bus_write(ADR_RX_IRQ, 2);
    fork
      push_bytes(8);
      poll_tx_cnt(12);
    join
    wait_irq_rx(1'b1, 2000);
    wait_rx_cnt(8, 2000);
    pop_check(8);
    wait_irq_rx(1'b0, 20);

    // Overflow with a long bit period and one byte already in the serializer
    bus_write(ADR_TX_BDR, 40);
    bus_write(ADR_RX_BDR, 40);
    bus_write(ADR_RX_SMP, 20);
    fork
      push_bytes(20);
      poll_tx_cnt(24);
    join
    read_expect(ADR_TX_CNT, BUS_W'(FIFO_DEPTH), "tx_cnt");
    repeat (20 - (FIFO_DEPTH + 1)) void'(exp_q.pop_back());   // Dropped at the full FIFO
    drain_rx(FIFO_DEPTH + 1, 20000);
    read_expect(ADR_TX_CNT, '0, "tx_cnt");
    read_expect(ADR_RX_CNT, '0, "rx_cnt");

    $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule : uart_ctl_tb
